// File: trap_consts.svh
`ifndef TRAP_CONSTS_SVH
`define TRAP_CONSTS_SVH

// datapath width, RV32 only
`define XLEN 32

// machine-mode CSR addresses
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MTVEC  12'h305

// mcause exception codes
`define MCAUSE_MISALIGNED 32'd0    // instruction address misaligned
`define MCAUSE_EBREAK     32'd3    // breakpoint
`define MCAUSE_ECALL      32'd11   // environment call from M-mode

// opcodes and fields the detector recognises
`define OPCODE_SYSTEM   7'b1110011
`define OPCODE_MISC_MEM 7'b0001111
`define FUNCT3_FENCEI   3'b001
`define FUNCT12_ECALL   12'h000
`define FUNCT12_EBREAK  12'h001
`define FUNCT12_MRET    12'h302

`endif

// File: trap_pkg.sv
`default_nettype none

package trap_pkg;

    // trap kind seen in the execute stage
    typedef enum logic [2:0] {
        trap_none       = 3'd0,
        trap_fencei     = 3'd1,
        trap_mret       = 3'd2,
        trap_ebreak     = 3'd3,
        trap_ecall      = 3'd4,
        trap_misaligned = 3'd5
    } trap_kind_e;

    // pre-trap handling FSM states
    typedef enum logic [1:0] {
        pth_idle         = 2'b00,
        pth_write_mepc   = 2'b01,   // mepc written, mcause next
        pth_write_mcause = 2'b10,   // mcause written
        pth_read_mtvec   = 2'b11    // handler address on trap_target
    } pth_state_e;

endpackage

`default_nettype wire

// File: trap_csr_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "trap_consts.svh"

// one CSR access port, combinational read, write at next clk edge
interface trap_csr_if;

    logic             write_enable;
    logic [11:0]      address;
    logic [`XLEN-1:0] write_data;
    logic [`XLEN-1:0] read_data;    // follows address in the same cycle

    modport requester (output write_enable, output address, output write_data,
                       input read_data);

    modport csr_side (input write_enable, input address, input write_data,
                      output read_data);

endinterface

`default_nettype wire

// File: trap_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "trap_consts.svh"

module trap_detector import trap_pkg::*; (
    input  wire              instr_valid,
    input  wire [`XLEN-1:0]  instr,
    input  wire              jump_taken,
    input  wire [`XLEN-1:0]  jump_target,
    output trap_kind_e       trap_kind
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic [11:0] funct12;
    logic        sys_regs_zero;
    logic        target_misaligned;

    // instruction fields
    assign opcode  = instr[6:0];
    assign rd      = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1     = instr[19:15];
    assign funct12 = instr[31:20];

    // ecall/ebreak/mret require funct3, rd and rs1 all zero
    assign sys_regs_zero = (funct3 == 3'b000) && (rd == 5'd0) && (rs1 == 5'd0);

    // no compressed support, so any nonzero low bit traps
    assign target_misaligned = jump_target[1:0] != 2'b00;

    always_comb begin
        trap_kind = trap_none;

        if (!instr_valid) begin
            trap_kind = trap_none;   // bubble
        end else if (jump_taken && target_misaligned) begin
            // misaligned jump wins over whatever the instruction is
            trap_kind = trap_misaligned;
        end else if (opcode == `OPCODE_SYSTEM) begin
            if (sys_regs_zero) begin
                case (funct12)
                    `FUNCT12_ECALL:  trap_kind = trap_ecall;
                    `FUNCT12_EBREAK: trap_kind = trap_ebreak;
                    `FUNCT12_MRET:   trap_kind = trap_mret;
                    default:         trap_kind = trap_none;   // csr ops, wfi etc
                endcase
            end
        end else if (opcode == `OPCODE_MISC_MEM) begin
            // plain FENCE is a no-op here
            if (funct3 == `FUNCT3_FENCEI) begin
                trap_kind = trap_fencei;
            end
        end
    end

endmodule

`default_nettype wire

// File: trap_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "trap_consts.svh"

module trap_controller import trap_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire trap_kind_e  trap_kind,
    input  wire [`XLEN-1:0]  pc,
    trap_csr_if.requester    csr,
    output logic [`XLEN-1:0] trap_target,   // redirect address
    output logic             ic_clean,      // icache clean for fence.i
    output logic             debug_mode,
    output logic             trap_done      // low = stall the pc
);

    pth_state_e       state;
    pth_state_e       next_state;
    logic [`XLEN-1:0] mcause_code;
    logic             ebreak_complete;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= pth_idle;
        end else begin
            state <= next_state;
        end
    end

    // ebreak handling finishes in the write_mcause state
    assign ebreak_complete = (state == pth_write_mcause) && (trap_kind == trap_ebreak);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            debug_mode <= 1'b0;
        end else if (trap_kind == trap_mret) begin
            debug_mode <= 1'b0;      // leaving the handler
        end else if (ebreak_complete) begin
            debug_mode <= 1'b1;
        end
    end

    always_comb begin
        case (trap_kind)
            trap_ebreak: mcause_code = `MCAUSE_EBREAK;
            trap_ecall:  mcause_code = `MCAUSE_ECALL;
            default:     mcause_code = `MCAUSE_MISALIGNED;
        endcase
    end

    always_comb begin
        ic_clean         = 1'b0;
        trap_done        = 1'b1;
        trap_target      = '0;
        csr.write_enable = 1'b0;
        csr.address      = 12'h000;
        csr.write_data   = '0;
        next_state       = pth_idle;

        case (trap_kind)
            trap_fencei: begin
                ic_clean = 1'b1;     // single cycle, no stall
            end

            trap_mret: begin
                // return to the instruction after the trapping one,
                // low bits dropped in case mepc was written unaligned
                csr.address = `CSR_MEPC;
                trap_target = {csr.read_data[`XLEN-1:2], 2'b00} + `XLEN'd4;
            end

            trap_ecall, trap_ebreak, trap_misaligned: begin
                case (state)
                    pth_idle: begin
                        csr.write_enable = 1'b1;
                        csr.address      = `CSR_MEPC;
                        csr.write_data   = pc;
                        trap_done        = 1'b0;
                        next_state       = pth_write_mepc;
                    end

                    pth_write_mepc: begin
                        csr.write_enable = 1'b1;
                        csr.address      = `CSR_MCAUSE;
                        csr.write_data   = mcause_code;
                        trap_done        = 1'b0;
                        next_state       = pth_write_mcause;
                    end

                    pth_write_mcause: begin
                        if (trap_kind == trap_ebreak) begin
                            next_state = pth_idle;   // no handler jump, debug mode instead
                        end else begin
                            csr.address = `CSR_MTVEC;
                            trap_target = csr.read_data;
                            trap_done   = 1'b0;
                            next_state  = pth_read_mtvec;
                        end
                    end

                    pth_read_mtvec: begin
                        // handler base now stable, release the stall
                        csr.address = `CSR_MTVEC;
                        trap_target = csr.read_data;
                        next_state  = pth_idle;
                    end

                    default: begin
                        next_state = pth_idle;
                    end
                endcase
            end

            default: begin
                next_state = pth_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: trap_csr_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "trap_consts.svh"

module trap_csr_file (
    input  wire              clk,
    input  wire              reset,
    trap_csr_if.csr_side     trap_port,
    input  wire              csr_sw_write_enable,
    input  wire [11:0]       csr_sw_address,
    input  wire [`XLEN-1:0]  csr_sw_write_data,
    output logic [`XLEN-1:0] csr_sw_read_data
);

    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mtvec;

    // merged write port
    logic             wr_en;
    logic [11:0]      wr_addr;
    logic [`XLEN-1:0] wr_data;

    // address decode shared by both read ports
    function automatic logic [`XLEN-1:0] read_csr(input logic [11:0] addr);
        logic [`XLEN-1:0] value;
        case (addr)
            `CSR_MEPC:   value = mepc;
            `CSR_MCAUSE: value = mcause;
            `CSR_MTVEC:  value = mtvec;
            default:     value = '0;   // unimplemented CSR
        endcase
        return value;
    endfunction

    always_comb begin
        trap_port.read_data = read_csr(trap_port.address);
        csr_sw_read_data    = read_csr(csr_sw_address);
    end

    // trap side owns the write port whenever it writes
    always_comb begin
        if (trap_port.write_enable) begin
            wr_en   = 1'b1;
            wr_addr = trap_port.address;
            wr_data = trap_port.write_data;
        end else begin
            wr_en   = csr_sw_write_enable;
            wr_addr = csr_sw_address;
            wr_data = csr_sw_write_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
            mtvec  <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MEPC:   mepc   <= wr_data;
                `CSR_MCAUSE: mcause <= wr_data;
                `CSR_MTVEC:  mtvec  <= wr_data;   // direct mode only
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: trap_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "trap_consts.svh"

module trap_unit import trap_pkg::*; (
    input  wire              clk,
    input  wire              reset,

    // execute stage
    input  wire              instr_valid,
    input  wire [`XLEN-1:0]  instr,
    input  wire              jump_taken,
    input  wire [`XLEN-1:0]  jump_target,
    input  wire [`XLEN-1:0]  pc,

    // software CSR access
    input  wire              csr_sw_write_enable,
    input  wire [11:0]       csr_sw_address,
    input  wire [`XLEN-1:0]  csr_sw_write_data,
    output logic [`XLEN-1:0] csr_sw_read_data,

    output logic [`XLEN-1:0] trap_target,
    output logic             ic_clean,
    output logic             debug_mode,
    output logic             trap_done
);

    trap_kind_e trap_kind;

    trap_csr_if csr_bus ();

    trap_detector u_detector (
        .instr_valid (instr_valid),
        .instr       (instr),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .trap_kind   (trap_kind)
    );

    trap_controller u_controller (
        .clk         (clk),
        .reset       (reset),
        .trap_kind   (trap_kind),
        .pc          (pc),
        .csr         (csr_bus.requester),
        .trap_target (trap_target),
        .ic_clean    (ic_clean),
        .debug_mode  (debug_mode),
        .trap_done   (trap_done)
    );

    trap_csr_file u_csr_file (
        .clk                 (clk),
        .reset               (reset),
        .trap_port           (csr_bus.csr_side),
        .csr_sw_write_enable (csr_sw_write_enable),
        .csr_sw_address      (csr_sw_address),
        .csr_sw_write_data   (csr_sw_write_data),
        .csr_sw_read_data    (csr_sw_read_data)
    );

endmodule

`default_nettype wire

// File: trap_unit_assert.sv
`timescale 1ns/100ps
`default_nettype none

module trap_unit_assert import trap_pkg::*; (
    input wire             clk,
    input wire             reset,
    input wire trap_kind_e trap_kind,
    input wire pth_state_e state,
    input wire             trap_done,
    input wire             ic_clean,
    input wire             csr_write_enable
);

    integer failures = 0;

    // longest stall is ecall or misaligned, three cycles
    property stall_bounded;
        @(posedge clk) disable iff (reset)
            (!trap_done) [*3] |=> trap_done;
    endproperty

    property clean_single_cycle;
        @(posedge clk) disable iff (reset)
            ic_clean |=> !ic_clean;
    endproperty

    // handler fetch only reads
    property no_write_in_read_mtvec;
        @(posedge clk) disable iff (reset)
            (state == pth_read_mtvec) |-> !csr_write_enable;
    endproperty

    property idle_without_trap;
        @(posedge clk) disable iff (reset)
            (trap_done && $past(trap_kind) == trap_none) |-> (state == pth_idle);
    endproperty

    assert property (stall_bounded) else begin
        failures = failures + 1;
        $error("trap_done low for more than three cycles");
    end

    assert property (clean_single_cycle) else begin
        failures = failures + 1;
        $error("ic_clean high for more than one cycle");
    end

    assert property (no_write_in_read_mtvec) else begin
        failures = failures + 1;
        $error("CSR write issued in read_mtvec");
    end

    assert property (idle_without_trap) else begin
        failures = failures + 1;
        $error("FSM not idle after a cycle with no trap");
    end

endmodule

`default_nettype wire

// File: trap_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "trap_consts.svh"

module trap_unit_tb;

    logic             clk;
    logic             reset;
    logic             instr_valid;
    logic [`XLEN-1:0] instr;
    logic             jump_taken;
    logic [`XLEN-1:0] jump_target;
    logic [`XLEN-1:0] pc;
    logic             csr_sw_write_enable;
    logic [11:0]      csr_sw_address;
    logic [`XLEN-1:0] csr_sw_write_data;
    logic [`XLEN-1:0] csr_sw_read_data;
    logic [`XLEN-1:0] trap_target;
    logic             ic_clean;
    logic             debug_mode;
    logic             trap_done;

    integer errors;
    integer checks;
    integer seed;
    logic   timed_out;

    // software writes scheduled for stall cycles 1..4 of the next issue
    logic             pend_en   [1:4];
    logic [11:0]      pend_addr [1:4];
    logic [`XLEN-1:0] pend_data [1:4];

    logic [`XLEN-1:0] mtvec_model;   // handler base the DUT should hold

    trap_unit DUT (
        .clk                 (clk),
        .reset               (reset),
        .instr_valid         (instr_valid),
        .instr               (instr),
        .jump_taken          (jump_taken),
        .jump_target         (jump_target),
        .pc                  (pc),
        .csr_sw_write_enable (csr_sw_write_enable),
        .csr_sw_address      (csr_sw_address),
        .csr_sw_write_data   (csr_sw_write_data),
        .csr_sw_read_data    (csr_sw_read_data),
        .trap_target         (trap_target),
        .ic_clean            (ic_clean),
        .debug_mode          (debug_mode),
        .trap_done           (trap_done)
    );

    bind trap_controller trap_unit_assert u_assert (
        .clk              (clk),
        .reset            (reset),
        .trap_kind        (trap_kind),
        .state            (state),
        .trap_done        (trap_done),
        .ic_clean         (ic_clean),
        .csr_write_enable (csr.write_enable)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic drive_idle();
        instr_valid         = 1'b0;
        instr               = 32'h0000_0013;   // nop
        jump_taken          = 1'b0;
        jump_target         = '0;
        csr_sw_write_enable = 1'b0;
        csr_sw_address      = 12'h000;
        csr_sw_write_data   = '0;
    endtask

    task automatic write_csr_sw(input logic [11:0] addr, input logic [`XLEN-1:0] data);
        @(negedge clk);
        drive_idle();
        csr_sw_write_enable = 1'b1;   // lands at the next rising edge
        csr_sw_address      = addr;
        csr_sw_write_data   = data;
        if (addr == `CSR_MTVEC) begin
            mtvec_model = data;
        end
    endtask

    task automatic check_csr_read(input logic [11:0] addr, input logic [`XLEN-1:0] expected);
        @(negedge clk);
        drive_idle();
        csr_sw_address = addr;
        #1;
        check_value($sformatf("csr_sw_read_data[%h]", addr), expected, csr_sw_read_data);
    endtask

    task automatic check_status(input logic exp_done, input logic exp_ic, input logic exp_dbg);
        @(negedge clk);
        drive_idle();
        #1;
        check_value("trap_done", exp_done, trap_done);
        check_value("ic_clean", exp_ic, ic_clean);
        check_value("debug_mode", exp_dbg, debug_mode);
    endtask

    task automatic apply_pending_write(input integer index);
        csr_sw_write_enable = 1'b0;
        if (index >= 1 && index <= 4) begin
            if (pend_en[index]) begin
                csr_sw_write_enable = 1'b1;
                csr_sw_address      = pend_addr[index];
                csr_sw_write_data   = pend_data[index];
            end
        end
    endtask

    task automatic note_mtvec_write(input integer index, input integer exp_stall);
        // trap side owns the CSR port in the first two cycles of a stalling trap
        if (index >= 1 && index <= 4) begin
            if (pend_en[index] && pend_addr[index] == `CSR_MTVEC &&
                !(exp_stall > 0 && index <= 2)) begin
                mtvec_model = pend_data[index];
            end
        end
    endtask

    task automatic issue_instr(input logic [`XLEN-1:0] op_instr, input logic [`XLEN-1:0] op_pc,
                               input logic op_jump, input logic [`XLEN-1:0] op_target,
                               input integer exp_stall, input logic target_check,
                               input logic [`XLEN-1:0] exp_target, input logic exp_ic,
                               input logic exp_dbg);
        integer waited;
        integer idx;
        logic   done_seen;
        waited    = 0;
        done_seen = 1'b0;
        @(negedge clk);
        drive_idle();
        instr_valid = 1'b1;
        instr       = op_instr;
        pc          = op_pc;
        jump_taken  = op_jump;
        jump_target = op_target;
        // inputs held until trap_done is seen high
        while (!done_seen && waited < 10) begin
            apply_pending_write(waited + 1);
            #1;
            if (!trap_done && waited == 2) begin
                // handler fetch cycle still shows the base from before the trap
                check_value("trap_target", mtvec_model, trap_target);
            end
            note_mtvec_write(waited + 1, exp_stall);
            if (trap_done) begin
                done_seen = 1'b1;
            end else begin
                waited = waited + 1;
                @(negedge clk);
            end
        end
        for (idx = 1; idx <= 4; idx = idx + 1) begin
            pend_en[idx] = 1'b0;
        end
        if (!done_seen) begin
            $display("trap_done stayed low for 10 cycles after instruction %h at pc %h",
                     op_instr, op_pc);
            errors    = errors + 1;
            timed_out = 1'b1;
        end else begin
            check_value("stall_cycles", exp_stall, waited);
            if (target_check) begin
                check_value("trap_target", exp_target, trap_target);
            end
            check_value("ic_clean", exp_ic, ic_clean);
            @(negedge clk);   // instruction retired
            drive_idle();
            #1;
            check_value("debug_mode", exp_dbg, debug_mode);
            check_value("ic_clean", 1'b0, ic_clean);
            check_value("trap_done", 1'b1, trap_done);
        end
    endtask

    task automatic report_bad_line(input logic [63:0] op);
        $display("vector line for op %0s is malformed", op);
        errors = errors + 1;
    endtask

    initial begin
        logic [63:0]        op;
        logic [8*128-1:0]   line;
        integer             fd;
        integer             rc;
        integer             idx;
        integer             idle_cycles;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   c;
        logic [`XLEN-1:0]   f_instr;
        logic [`XLEN-1:0]   f_pc;
        logic [`XLEN-1:0]   f_jump;
        logic [`XLEN-1:0]   f_jtgt;
        integer             f_stall;
        logic [`XLEN-1:0]   f_tchk;
        logic [`XLEN-1:0]   f_tgt;
        logic [`XLEN-1:0]   f_ic;
        logic [`XLEN-1:0]   f_dbg;

        errors      = 0;
        checks      = 0;
        seed        = 10439;
        timed_out   = 1'b0;
        mtvec_model = '0;
        reset       = 1'b1;
        pc          = '0;
        drive_idle();
        for (idx = 1; idx <= 4; idx = idx + 1) begin
            pend_en[idx]   = 1'b0;
            pend_addr[idx] = 12'h000;
            pend_data[idx] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("trap_unit_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open trap_unit_vectors.txt");
            errors = errors + 1;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                rc = $fscanf(fd, "%s", op);
                if (rc == 1) begin
                    case (op)
                        "#": rc = $fgets(line, fd);   // comment line
                        "S": begin
                            rc = $fscanf(fd, "%h %h %h", a, b, c);
                            if (rc != 3) report_bad_line(op);
                            else check_status(a[0], b[0], c[0]);
                        end
                        "W": begin
                            rc = $fscanf(fd, "%h %h", a, b);
                            if (rc != 2) report_bad_line(op);
                            else write_csr_sw(a[11:0], b);
                        end
                        "R": begin
                            rc = $fscanf(fd, "%h %h", a, b);
                            if (rc != 2) report_bad_line(op);
                            else check_csr_read(a[11:0], b);
                        end
                        "P": begin
                            rc = $fscanf(fd, "%d %h %h", idx, b, c);
                            if (rc != 3 || idx < 1 || idx > 4) begin
                                report_bad_line(op);
                            end else begin
                                pend_en[idx]   = 1'b1;
                                pend_addr[idx] = b[11:0];
                                pend_data[idx] = c;
                            end
                        end
                        "I": begin
                            rc = $fscanf(fd, "%h %h %h %h %d %h %h %h %h", f_instr, f_pc,
                                         f_jump, f_jtgt, f_stall, f_tchk, f_tgt, f_ic, f_dbg);
                            if (rc != 9) report_bad_line(op);
                            else issue_instr(f_instr, f_pc, f_jump[0], f_jtgt, f_stall,
                                             f_tchk[0], f_tgt, f_ic[0], f_dbg[0]);
                        end
                        "N": begin
                            rc = $fscanf(fd, "%d", idx);
                            if (rc != 1) report_bad_line(op);
                            else repeat (idx) begin
                                @(negedge clk);
                                drive_idle();
                            end
                        end
                        default: begin
                            $display("unknown vector op %0s", op);
                            errors = errors + 1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        idle_cycles = 2 + ($unsigned($random(seed)) % 4);
        repeat (idle_cycles) @(negedge clk);
        errors = errors + DUT.u_controller.u_assert.failures;   // concurrent assertions
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: trap_unit_vectors.txt
# op S: trap_done ic_clean debug_mode | W: addr data | R: addr expected | N: idle cycles
# op P: stall_cycle addr data | I: instr pc jump_taken jump_target stall tgt_chk target ic_clean debug_after
# reset values
S 1 0 0
R 341 00000000
R 342 00000000
R 305 00000000
W 305 00000100
R 305 00000100
# ecall
I 00000073 00000200 0 00000000 3 1 00000100 0 0
R 341 00000200
R 342 0000000b
# taken jump to a misaligned target
I 0000006f 00000300 1 00001002 3 1 00000100 0 0
R 341 00000300
R 342 00000000
# misaligned jump wins over ecall
I 00000073 00000380 1 00000001 3 1 00000100 0 0
R 341 00000380
R 342 00000000
# misaligned target without a taken jump
I 00000013 000003c0 0 00000003 0 0 00000000 0 0
R 341 00000380
# ebreak enters debug mode
I 00100073 00000400 0 00000000 2 0 00000000 0 1
R 341 00000400
R 342 00000003
S 1 0 1
# mret from an unaligned mepc
W 341 00000523
I 30200073 00000600 0 00000000 0 1 00000524 0 0
S 1 0 0
# fence.i leaves the CSRs alone
I 0000100f 00000700 0 00000000 0 0 00000000 1 0
R 341 00000523
R 342 00000003
R 305 00000100
# ecall encoding with rd nonzero
I 000000f3 00000800 0 00000000 0 0 00000000 0 0
R 341 00000523
# unimplemented csr
W 300 12345678
R 300 00000000
# mtvec write dropped in stall cycle 1, kept in stall cycle 3
P 1 305 0000aaaa
P 3 305 0000bbbb
I 00000073 00000900 0 00000000 3 1 0000bbbb 0 0
R 305 0000bbbb
R 341 00000900
R 342 0000000b
N 3
S 1 0 0

// File: trap_unit.f
+incdir+.
trap_pkg.sv
trap_csr_if.sv
trap_detector.sv
trap_controller.sv
trap_csr_file.sv
trap_unit.sv
trap_unit_assert.sv
trap_unit_tb.sv

// File: Bender.yml
package:
  name: trap_unit

export_include_dirs:
  - .

sources:
  - files:
      - trap_pkg.sv
      - trap_csr_if.sv
      - trap_detector.sv
      - trap_controller.sv
      - trap_csr_file.sv
      - trap_unit.sv
  - target: test
    files:
      - trap_unit_assert.sv
      - trap_unit_tb.sv
